/* source/tinker_pkg.sv */
package tinker_pkg;

    localparam int word_w    = 64;
    localparam int instr_w   = 32;
    localparam int reg_idx_w = 5;
    localparam int imm_w     = 12;  // width of the L field
    localparam int num_regs  = 32;

    typedef logic [word_w-1:0]    word_t;
    typedef logic [word_w-1:0]    addr_t;   // byte address
    typedef logic [instr_w-1:0]   instr_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [imm_w-1:0]     imm_t;

    // tinker opcode field in bits 31:27
    typedef enum logic [4:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,
        op_shftri = 5'b00101,
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_br     = 5'b01000,
        op_brr    = 5'b01001,
        op_brr_l  = 5'b01010,
        op_brnz   = 5'b01011,
        op_brgt   = 5'b01110,
        op_halt   = 5'b01111,
        op_load   = 5'b10000,
        op_mov    = 5'b10001,
        op_mov_l  = 5'b10010,
        op_store  = 5'b10011,
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011
    } opcode_t;

    localparam addr_t reset_pc = 64'h2000;  // first fetch address
    localparam addr_t pc_step  = 64'd4;

endpackage

/* source/id_ex_if.sv */
`timescale 1ns/1ps

// decode/execute register contents
interface id_ex_if import tinker_pkg::*; ();

    logic     valid;
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    imm;       // L, already sign-extended
    addr_t    pc;
    word_t    a;         // value of rs
    word_t    b;         // value of rt
    word_t    rd_val;
    logic     imm_form;

    modport producer (output valid, op, rd, rs, rt, imm, pc, a, b, rd_val, imm_form);
    modport consumer (input  valid, op, rd, rs, rt, imm, pc, a, b, rd_val, imm_form);

endinterface

/* source/ex_mem_if.sv */
`timescale 1ns/1ps

// execute/memory register and the forwarding source closest to execute
interface ex_mem_if import tinker_pkg::*; ();

    logic     valid;
    logic     reg_write;  // gated by valid
    logic     mem_read;
    logic     mem_write;  // drives dmem_we directly
    reg_idx_t rd;
    word_t    result;
    addr_t    addr;
    word_t    wr_data;
    opcode_t  op;

    modport producer (output valid, reg_write, mem_read, mem_write, rd, result, addr, wr_data, op);
    modport consumer (input  valid, reg_write, mem_read, mem_write, rd, result, addr, wr_data, op);

endinterface

/* source/tinker_regfile.sv */
`timescale 1ns/1ps

module tinker_regfile import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t rd,
    output word_t    a,
    output word_t    b,
    output word_t    rd_val,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data
);

    word_t regs [num_regs];

    // write-first so that a retiring value reaches decode in the same cycle
    assign a      = (wb_en && (wb_rd == rs)) ? wb_data : regs[rs];
    assign b      = (wb_en && (wb_rd == rt)) ? wb_data : regs[rt];
    assign rd_val = (wb_en && (wb_rd == rd)) ? wb_data : regs[rd];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;  // r0 is an ordinary register
        end
    end

endmodule

/* source/tinker_alu.sv */
`timescale 1ns/1ps

module tinker_alu import tinker_pkg::*; (
    input  opcode_t op,
    input  word_t   op1,
    input  word_t   op2,
    input  word_t   rd_val,
    output word_t   result,
    output addr_t   addr,
    output logic    reg_write,
    output logic    mem_read,
    output logic    mem_write
);

    always_comb begin
        result    = '0;
        reg_write = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (op)
            op_add, op_addi:     result = op1 + op2;
            op_sub, op_subi:     result = op1 - op2;
            op_and:              result = op1 & op2;
            op_or:               result = op1 | op2;
            op_xor:              result = op1 ^ op2;
            op_not:              result = ~op1;
            op_shftr, op_shftri: result = op1 >> op2[5:0];
            op_shftl, op_shftli: result = op1 << op2[5:0];
            op_mov:              result = op1;
            op_mov_l:            result = {rd_val[word_w-1:imm_w], op2[imm_w-1:0]};
            op_load:             mem_read = 1'b1;  // data picked up in writeback
            op_store: begin
                result    = op1;  // rs is the store data
                reg_write = 1'b0;
                mem_write = 1'b1;
            end
            default:             reg_write = 1'b0;  // branches and halt
        endcase
    end

    // store is based on rd, load on rs
    assign addr = (op == op_store) ? rd_val + op2 : op1 + op2;

endmodule

/* source/tinker_fetch.sv */
`timescale 1ns/1ps

module tinker_fetch import tinker_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   redirect,
    input  addr_t  target,
    input  instr_t imem_data,
    output addr_t  imem_addr,
    output logic   fd_valid,
    output addr_t  fd_pc,
    output instr_t fd_instr
);

    addr_t pc;

    assign imem_addr = pc;  // instruction memory answers in the same cycle

    // redirect has priority over a load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= reset_pc;
            fd_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= target;
            fd_valid <= 1'b0;  // squash the wrong-path word
        end else if (!stall) begin
            pc       <= pc + pc_step;
            fd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !redirect) begin
            fd_pc    <= pc;
            fd_instr <= imem_data;
        end
    end

endmodule

/* source/tinker_decode.sv */
`timescale 1ns/1ps

module tinker_decode import tinker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fd_valid,
    input  addr_t     fd_pc,
    input  instr_t    fd_instr,
    output logic      stall,
    input  logic      redirect,
    input  logic      wb_en,
    input  reg_idx_t  wb_rd,
    input  word_t     wb_data,
    id_ex_if.producer id_ex
);

    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    imm_t     l_field;
    word_t    imm_ext;
    logic     imm_form;
    logic     reads_rt;
    word_t    a;
    word_t    b;
    word_t    rd_val;

    // field split
    assign op      = opcode_t'(fd_instr[31:27]);
    assign rd      = fd_instr[26:22];
    assign rs      = fd_instr[21:17];
    assign rt      = fd_instr[16:12];
    assign l_field = fd_instr[imm_w-1:0];
    assign imm_ext = {{(word_w-imm_w){l_field[imm_w-1]}}, l_field};

    always_comb begin
        case (op)
            op_addi, op_subi, op_shftri, op_shftli,
            op_mov_l, op_brr_l, op_store, op_load: imm_form = 1'b1;
            default:                               imm_form = 1'b0;
        endcase
    end

    // register-register forms only
    always_comb begin
        case (op)
            op_add, op_sub, op_and, op_or, op_xor,
            op_shftr, op_shftl, op_brgt: reads_rt = 1'b1;
            default:                     reads_rt = 1'b0;
        endcase
    end

    // load in execute whose target this instruction needs
    assign stall = fd_valid && id_ex.valid && (id_ex.op == op_load) &&
                   ((id_ex.rd == rs) || (reads_rt && (id_ex.rd == rt)));

    tinker_regfile regfile_i (
        .clk     (clk),
        .reset   (reset),
        .rs      (rs),
        .rt      (rt),
        .rd      (rd),
        .a       (a),
        .b       (b),
        .rd_val  (rd_val),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            id_ex.valid <= 1'b0;
        else
            id_ex.valid <= fd_valid && !stall && !redirect;  // bubble on stall or flush
    end

    always_ff @(posedge clk) begin
        id_ex.op       <= op;
        id_ex.rd       <= rd;
        id_ex.rs       <= rs;
        id_ex.rt       <= rt;
        id_ex.imm      <= imm_ext;
        id_ex.pc       <= fd_pc;
        id_ex.a        <= a;
        id_ex.b        <= b;
        id_ex.rd_val   <= rd_val;
        id_ex.imm_form <= imm_form;
    end

endmodule

/* source/tinker_execute.sv */
`timescale 1ns/1ps

module tinker_execute import tinker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    id_ex_if.consumer  id_ex,
    input  logic       wb_en,
    input  reg_idx_t   wb_rd,
    input  word_t      wb_data,
    output logic       redirect,
    output addr_t      target,
    ex_mem_if.producer ex_mem
);

    word_t a_fwd;
    word_t b_fwd;
    word_t rd_fwd;
    word_t op1;
    word_t op2;
    word_t alu_result;
    addr_t alu_addr;
    logic  alu_reg_write;
    logic  alu_mem_read;
    logic  alu_mem_write;
    logic  taken;

    // youngest producer first; a load in execute/memory is covered by the stall
    function automatic word_t forward(input reg_idx_t idx, input word_t val);
        if (ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.rd == idx))
            return ex_mem.result;
        else if (wb_en && (wb_rd == idx))
            return wb_data;
        else
            return val;
    endfunction

    always_comb begin
        a_fwd  = forward(id_ex.rs, id_ex.a);
        b_fwd  = forward(id_ex.rt, id_ex.b);
        rd_fwd = forward(id_ex.rd, id_ex.rd_val);
    end

    assign op1 = (id_ex.op == op_addi || id_ex.op == op_subi) ? rd_fwd : a_fwd;
    assign op2 = id_ex.imm_form ? id_ex.imm : b_fwd;

    tinker_alu alu_i (
        .op        (id_ex.op),
        .op1       (op1),
        .op2       (op2),
        .rd_val    (rd_fwd),
        .result    (alu_result),
        .addr      (alu_addr),
        .reg_write (alu_reg_write),
        .mem_read  (alu_mem_read),
        .mem_write (alu_mem_write)
    );

    always_comb begin
        taken  = 1'b0;
        target = rd_fwd;
        case (id_ex.op)
            op_br:   taken = 1'b1;
            op_brr: begin
                taken  = 1'b1;
                target = id_ex.pc + rd_fwd;
            end
            op_brr_l: begin
                taken  = 1'b1;
                target = id_ex.pc + id_ex.imm;
            end
            op_brnz: taken = (a_fwd != '0);
            op_brgt: taken = ($signed(a_fwd) > $signed(b_fwd));
            default: taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.valid && taken;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.valid     <= id_ex.valid;
            ex_mem.reg_write <= id_ex.valid && alu_reg_write;
            ex_mem.mem_read  <= id_ex.valid && alu_mem_read;
            ex_mem.mem_write <= id_ex.valid && alu_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.rd      <= id_ex.rd;
        ex_mem.result  <= alu_result;
        ex_mem.addr    <= alu_addr;
        ex_mem.wr_data <= alu_result;  // store data comes out on result
        ex_mem.op      <= id_ex.op;
    end

endmodule

/* source/tinker_writeback.sv */
`timescale 1ns/1ps

module tinker_writeback import tinker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    ex_mem_if.consumer ex_mem,
    input  word_t     dmem_rdata,
    output logic      wb_en,
    output reg_idx_t  wb_rd,
    output word_t     wb_data,
    output logic      hlt
);

    logic halt_retire;  // halt sitting in memory/writeback

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en       <= 1'b0;
            halt_retire <= 1'b0;
            hlt         <= 1'b0;
        end else begin
            wb_en       <= ex_mem.reg_write;
            halt_retire <= ex_mem.valid && (ex_mem.op == op_halt);
            hlt         <= hlt || halt_retire;  // sticky until reset
        end
    end

    // load data is sampled in the cycle the load sits in execute/memory
    always_ff @(posedge clk) begin
        wb_rd   <= ex_mem.rd;
        wb_data <= ex_mem.mem_read ? dmem_rdata : ex_mem.result;
    end

endmodule

/* source/tinker_core.sv */
`timescale 1ns/1ps

module tinker_core import tinker_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    output addr_t  imem_addr,
    input  instr_t imem_data,
    output addr_t  dmem_addr,
    input  word_t  dmem_rdata,
    output word_t  dmem_wdata,
    output logic   dmem_we,
    output logic   hlt
);

    logic     stall;
    logic     redirect;
    addr_t    target;
    logic     fd_valid;
    addr_t    fd_pc;
    instr_t   fd_instr;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    // data port straight off execute/memory
    assign dmem_addr  = ex_mem.addr;
    assign dmem_wdata = ex_mem.wr_data;
    assign dmem_we    = ex_mem.mem_write;

    tinker_fetch fetch_i (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .fd_valid  (fd_valid),
        .fd_pc     (fd_pc),
        .fd_instr  (fd_instr)
    );

    tinker_decode decode_i (
        .clk      (clk),
        .reset    (reset),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_instr (fd_instr),
        .stall    (stall),
        .redirect (redirect),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .id_ex    (id_ex.producer)
    );

    tinker_execute execute_i (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex.consumer),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .redirect (redirect),
        .target   (target),
        .ex_mem   (ex_mem.producer)
    );

    tinker_writeback writeback_i (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem.consumer),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .hlt        (hlt)
    );

endmodule

/* dv/tinker_program.svh */
`ifndef TINKER_PROGRAM_SVH
`define TINKER_PROGRAM_SVH

// L field of the stores that sit in a branch shadow
localparam int    poison_l    = 'h7f0;
localparam addr_t poison_addr = addr_t'(poison_l);

instr_t prog[$];
addr_t  exp_addr[$];
word_t  exp_data[$];

// op | rd | rs | rt | L
function automatic instr_t encode_instr(opcode_t op, int rd, int rs, int rt, int l);
    return {op, 5'(rd), 5'(rs), 5'(rt), 12'(l)};
endfunction

task automatic add_poison();
    prog.push_back(encode_instr(op_store, 0, 1, 0, poison_l));
endtask

// r0 stays zero and is the base of every data access
task automatic build_program();
    prog.push_back(encode_instr(op_load, 1, 0, 0, 0));       // r1 = x
    prog.push_back(encode_instr(op_load, 2, 0, 0, 8));       // r2 = y
    prog.push_back(encode_instr(op_add, 3, 1, 2, 0));        // load-use on rt
    prog.push_back(encode_instr(op_store, 0, 3, 0, 'h100));
    prog.push_back(encode_instr(op_sub, 4, 1, 2, 0));
    prog.push_back(encode_instr(op_store, 0, 4, 0, 'h108));
    prog.push_back(encode_instr(op_and, 5, 1, 2, 0));
    prog.push_back(encode_instr(op_store, 0, 5, 0, 'h110));
    prog.push_back(encode_instr(op_or, 5, 1, 2, 0));
    prog.push_back(encode_instr(op_store, 0, 5, 0, 'h118));
    prog.push_back(encode_instr(op_xor, 5, 1, 2, 0));
    prog.push_back(encode_instr(op_store, 0, 5, 0, 'h120));
    prog.push_back(encode_instr(op_not, 5, 1, 0, 0));
    prog.push_back(encode_instr(op_store, 0, 5, 0, 'h128));
    prog.push_back(encode_instr(op_shftr, 5, 1, 2, 0));
    prog.push_back(encode_instr(op_store, 0, 5, 0, 'h130));
    prog.push_back(encode_instr(op_shftl, 5, 1, 2, 0));
    prog.push_back(encode_instr(op_store, 0, 5, 0, 'h138));
    prog.push_back(encode_instr(op_mov, 6, 1, 0, 0));
    prog.push_back(encode_instr(op_addi, 6, 6, 0, 100));     // rd from execute/memory
    prog.push_back(encode_instr(op_store, 0, 6, 0, 'h140));
    prog.push_back(encode_instr(op_subi, 6, 6, 0, 300));     // rd from writeback
    prog.push_back(encode_instr(op_store, 0, 6, 0, 'h148));
    prog.push_back(encode_instr(op_mov, 7, 2, 0, 0));
    prog.push_back(encode_instr(op_shftri, 7, 7, 0, 7));
    prog.push_back(encode_instr(op_store, 0, 7, 0, 'h150));
    prog.push_back(encode_instr(op_shftli, 7, 7, 0, 3));
    prog.push_back(encode_instr(op_store, 0, 7, 0, 'h158));
    prog.push_back(encode_instr(op_mov_l, 7, 0, 0, 'habc));
    prog.push_back(encode_instr(op_store, 0, 7, 0, 'h160));
    prog.push_back(encode_instr(op_load, 8, 0, 0, 'h100));   // reads back x + y
    prog.push_back(encode_instr(op_add, 9, 8, 2, 0));        // load-use on rs
    prog.push_back(encode_instr(op_store, 0, 9, 0, 'h168));
    prog.push_back(encode_instr(op_mov_l, 10, 0, 0, 1));
    prog.push_back(encode_instr(op_shftli, 10, 10, 0, 13));  // r10 = 0x2000
    prog.push_back(encode_instr(op_mov, 11, 10, 0, 0));
    prog.push_back(encode_instr(op_addi, 11, 11, 0, 156));
    prog.push_back(encode_instr(op_br, 11, 0, 0, 0));
    add_poison();
    prog.push_back(encode_instr(op_store, 0, 11, 0, 'h170)); // word 39
    prog.push_back(encode_instr(op_mov_l, 12, 0, 0, 8));
    prog.push_back(encode_instr(op_brr, 12, 0, 0, 0));
    add_poison();
    prog.push_back(encode_instr(op_store, 0, 12, 0, 'h178));
    prog.push_back(encode_instr(op_brr_l, 0, 0, 0, 8));
    add_poison();
    prog.push_back(encode_instr(op_subi, 13, 13, 0, 5));     // r13 = -5
    prog.push_back(encode_instr(op_mov, 14, 10, 0, 0));
    prog.push_back(encode_instr(op_addi, 14, 14, 0, 204));
    prog.push_back(encode_instr(op_brnz, 14, 13, 0, 0));     // taken
    add_poison();
    prog.push_back(encode_instr(op_store, 0, 13, 0, 'h180)); // word 51
    prog.push_back(encode_instr(op_brnz, 14, 0, 0, 0));      // not taken
    prog.push_back(encode_instr(op_store, 0, 14, 0, 'h188));
    prog.push_back(encode_instr(op_mov, 15, 10, 0, 0));
    prog.push_back(encode_instr(op_addi, 15, 15, 0, 232));
    prog.push_back(encode_instr(op_brgt, 15, 0, 13, 0));     // 0 > -5 signed
    add_poison();
    prog.push_back(encode_instr(op_store, 0, 15, 0, 'h190)); // word 58
    prog.push_back(encode_instr(op_brgt, 15, 13, 0, 0));     // -5 > 0 fails
    prog.push_back(encode_instr(op_store, 0, 9, 0, 'h198));
    prog.push_back(encode_instr(op_halt, 0, 0, 0, 0));
endtask

task automatic expect_store(input addr_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// store sequence of the program above, worked out from the ISA
task automatic compute_expected_stores(input word_t x, input word_t y);
    word_t shr7;
    word_t shl3;
    shr7 = y >> 7;
    shl3 = shr7 << 3;
    expect_store(64'h100, x + y);
    expect_store(64'h108, x - y);
    expect_store(64'h110, x & y);
    expect_store(64'h118, x | y);
    expect_store(64'h120, x ^ y);
    expect_store(64'h128, ~x);
    expect_store(64'h130, x >> y[5:0]);
    expect_store(64'h138, x << y[5:0]);
    expect_store(64'h140, x + 64'd100);
    expect_store(64'h148, x + 64'd100 - 64'd300);
    expect_store(64'h150, shr7);
    expect_store(64'h158, shl3);
    expect_store(64'h160, {shl3[63:12], 12'habc});  // upper 52 bits kept
    expect_store(64'h168, x + y + y);
    expect_store(64'h170, reset_pc + 64'd156);      // br target itself
    expect_store(64'h178, 64'd8);
    expect_store(64'h180, 64'd0 - 64'd5);
    expect_store(64'h188, reset_pc + 64'd204);
    expect_store(64'h190, reset_pc + 64'd232);
    expect_store(64'h198, x + y + y);
endtask

`endif

/* dv/tinker_core_tb.sv */
`timescale 1ns/1ps

module tinker_core_tb import tinker_pkg::*; ();

    localparam int     timeout_cycles = 2000;
    localparam int     post_hlt_cycles = 20;
    localparam instr_t halt_word = {op_halt, 27'd0};

    logic   clk;
    logic   reset;
    addr_t  imem_addr;
    instr_t imem_data;
    addr_t  dmem_addr;
    word_t  dmem_rdata;
    word_t  dmem_wdata;
    logic   dmem_we;
    logic   hlt;

    instr_t imem [128];
    word_t  dmem [256];
    addr_t  imem_word;
    int     seed;
    int     store_idx;  // next entry of the expected store table

    `include "tinker_program.svh"

    tinker_core tinker_core_i (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // words outside the program read as halt
    assign imem_word = (imem_addr - reset_pc) >> 2;
    assign imem_data = (imem_word < 64'd128) ? imem[imem_word[6:0]] : halt_word;

    assign dmem_rdata = dmem[dmem_addr[10:3]];  // same-cycle read

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[10:3]] <= dmem_wdata;
        end
    end

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_store();
        assert (!hlt) else begin
            $display("store to 0x%h issued after hlt was raised", dmem_addr);
            stop_with_failure();
        end
        assert (dmem_addr != poison_addr) else begin
            $display("store in a branch shadow was not squashed, time %0d ns", $time);
            stop_with_failure();
        end
        assert (store_idx < exp_addr.size()) else begin
            $display("more stores than expected, extra one at %0d ns", $time);
            stop_with_failure();
        end
        assert (dmem_addr == exp_addr[store_idx]) else begin
            $display("Error at %0d ns: dmem_addr = 0x%h, expected 0x%h",
                     $time, dmem_addr, exp_addr[store_idx]);
            stop_with_failure();
        end
        assert (dmem_wdata == exp_data[store_idx]) else begin
            $display("Error at %0d ns: dmem_wdata = 0x%h, expected 0x%h",
                     $time, dmem_wdata, exp_data[store_idx]);
            stop_with_failure();
        end
        store_idx++;
    endtask

    // data port is stable mid-cycle
    always @(negedge clk) begin
        if (!reset && dmem_we) begin
            check_store();
        end
    end

    initial begin
        word_t x;
        word_t y;
        int    cycles;
        reset     = 1'b1;
        store_idx = 0;
        seed      = 32'hd89c;
        x = {$random(seed), $random(seed)};
        y = {$random(seed), $random(seed)};

        build_program();
        for (int i = 0; i < 128; i++) begin
            if (i < prog.size())
                imem[i] = prog[i];
            else
                imem[i] = halt_word;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= '0;
        end
        dmem[0] <= x;  // operands of the first two loads
        dmem[1] <= y;
        compute_expected_stores(x, y);

        repeat (4) @(posedge clk);
        // fetch address and outputs held by reset
        assert (imem_addr == reset_pc) else begin
            $display("Error at %0d ns: imem_addr = 0x%h, expected 0x%h",
                     $time, imem_addr, reset_pc);
            stop_with_failure();
        end
        assert (!dmem_we && !hlt) else begin
            $display("dmem_we or hlt is high while reset is asserted");
            stop_with_failure();
        end
        #1 reset = 1'b0;

        cycles = 0;
        while (!hlt) begin
            if (cycles >= timeout_cycles) begin
                $display("timeout, hlt not raised within %0d cycles", timeout_cycles);
                stop_with_failure();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        assert (store_idx == exp_addr.size()) else begin
            $display("hlt rose after %0d of %0d stores", store_idx, exp_addr.size());
            stop_with_failure();
        end

        // hlt is sticky and the monitor catches any late store
        for (int i = 0; i < post_hlt_cycles; i++) begin
            @(negedge clk);
            assert (hlt) else begin
                $display("hlt dropped at %0d ns", $time);
                stop_with_failure();
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tinker_core.f */
+incdir+dv
source/tinker_pkg.sv
source/id_ex_if.sv
source/ex_mem_if.sv
source/tinker_regfile.sv
source/tinker_alu.sv
source/tinker_fetch.sv
source/tinker_decode.sv
source/tinker_execute.sv
source/tinker_writeback.sv
source/tinker_core.sv
dv/tinker_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tinker_core_tb -f tinker_core.f

# the simulation exits non-zero on failure, the log search decides the result
./obj_dir/Vtinker_core_tb | tee sim.log
grep -q "^=== PASS ===$" sim.log
